//--- include/bridge_settings.svh
`ifndef BRIDGE_SETTINGS_SVH
`define BRIDGE_SETTINGS_SVH

// data, address and ring index width
`define BRIDGE_DATA_W 32

// inter-core message width
`define BRIDGE_MSG_W 4

// words reserved in front of a thread for its header
`define BRIDGE_HEADER_SPACE 8

// last idle count before the exit flag is raised
`define BRIDGE_IDLE_MAX 15

// index bits below the active bit
`define BRIDGE_INDEX_LOW_W 31

`endif

//--- verilog/bridge_pkg.sv
`include "bridge_settings.svh"

package bridge_pkg;

  // core execution state, as reported by the core
  typedef enum logic [4:0] {
    WAIT_FOR_START,
    READ_COND,
    READ_SRC1,
    READ_SRC0,
    READ_DST,
    START_READ_CMD,
    READ_MEM_SIZE,
    WRITE_REG_IP,
    WRITE_DST,
    WRITE_SRC1,
    WRITE_SRC0,
    WRITE_COND,
    ALU_BEGIN,
    FINISH_BEGIN,
    FINISH_END,
    OTHER
  } core_state_e;

  // messages exchanged between cores
  typedef enum logic [`BRIDGE_MSG_W-1:0] {
    NONE = 0,
    RESET,
    START,
    END,
    FORK_DONE,
    STOP_DONE,
    CHAN_NO_RESULTS,
    CHAN_RES_RD,
    CHAN_RES_WR
  } cpu_msg_e;

  typedef enum logic [2:0] {
    STEP_INIT,
    STEP_CHECK,
    STEP_LATCH,
    STEP_PULSE,
    STEP_RELEASE,
    STEP_RUN
  } rst_step_e;

  // ring index against own index
  typedef enum logic [1:0] {
    REL_NONE = 0,
    REL_LOWER = 1,
    REL_HIGHER = 2,
    REL_SAME = 3
  } cpu_rel_e;

endpackage

//--- verilog/ring_if.sv
`timescale 1ns/1ps

`include "bridge_settings.svh"

// token status shared by the sequencer, handshake and messenger
interface ring_if;
  // own ring index, latched during the reset sequence
  logic [`BRIDGE_DATA_W-1:0] my_index;
  // reset sequence finished
  logic running;
  // token held, core being served
  logic online;
  // current core state served
  logic done;

  modport seq (output my_index, output running, input online);

  modport hs (output online, input done, input my_index, input running);

  modport msg (output done, input online, input running);

endinterface

//--- verilog/reset_sequencer.sv
`timescale 1ns/1ps

`include "bridge_settings.svh"

module reset_sequencer (
  input  logic                      clk,
  input  logic                      ext_rst_b,
  input  bridge_pkg::core_state_e   core_state,
  input  logic [`BRIDGE_DATA_W-1:0] cpu_index,
  ring_if.seq                       ring,
  output logic                      core_rst,
  output logic                      ext_rst_e,
  output logic                      dispatcher_q,
  output logic                      bus_busy,
  output bridge_pkg::cpu_msg_e      reset_msg
);
  import bridge_pkg::*;

  rst_step_e step;

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      step <= STEP_INIT;
      dispatcher_q <= 1'b0;
    end else begin
      case (step)
        STEP_INIT: begin
          dispatcher_q <= 1'b0;
          step <= STEP_CHECK;
        end
        // a finished core keeps its old index
        STEP_CHECK: step <= (core_state == FINISH_END) ? STEP_PULSE : STEP_LATCH;
        STEP_LATCH: step <= STEP_PULSE;
        STEP_PULSE: step <= STEP_RELEASE;
        STEP_RELEASE: begin
          dispatcher_q <= 1'b1;
          step <= STEP_RUN;
        end
        STEP_RUN: begin
          // thread over and token released, start again
          if (core_state == FINISH_END && !ring.online) begin
            step <= STEP_INIT;
          end
        end
        default: step <= STEP_INIT;
      endcase
    end
  end

  // index taken from the ring once per sequence
  always_ff @(posedge clk) begin
    if (step == STEP_LATCH) begin
      ring.my_index <= cpu_index;
    end
  end

  assign ring.running = (step == STEP_RUN);

  // one-cycle pulses decoded from the step
  assign core_rst = (step == STEP_PULSE);
  assign bus_busy = (step == STEP_PULSE);
  assign ext_rst_e = (step == STEP_PULSE) && (core_state != FINISH_END);
  assign reset_msg = (step == STEP_LATCH) ? RESET : NONE;

  a_core_rst_single: assert property (
    @(posedge clk) disable iff (ext_rst_b) core_rst |=> !core_rst
  );

endmodule

//--- verilog/token_handshake.sv
`timescale 1ns/1ps

`include "bridge_settings.svh"

module token_handshake (
  input  logic                      clk,
  input  logic                      ext_rst_b,
  input  logic                      next_cpu_req,
  input  logic [`BRIDGE_DATA_W-1:0] cpu_index,
  ring_if.hs                        ring,
  output logic                      next_cpu_ack,
  output bridge_pkg::cpu_rel_e      cpu_ind_rel
);
  import bridge_pkg::*;

  localparam int LOW_W = `BRIDGE_INDEX_LOW_W;

  logic [LOW_W-1:0] ring_low;
  logic [LOW_W-1:0] own_low;
  logic             match;

  // active bit left out of the ordering
  assign ring_low = cpu_index[LOW_W-1:0];
  assign own_low = ring.my_index[LOW_W-1:0];

  // token addressed to this core, only once the sequence is done
  assign match = next_cpu_req && ring.running && (cpu_index == ring.my_index);

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      cpu_ind_rel <= REL_NONE;
    end else if (next_cpu_req) begin
      if (ring_low < own_low) begin
        cpu_ind_rel <= REL_LOWER;
      end else if (ring_low > own_low) begin
        cpu_ind_rel <= REL_HIGHER;
      end else if (cpu_index == ring.my_index) begin
        cpu_ind_rel <= REL_SAME;
      end
    end else if (next_cpu_ack) begin
      cpu_ind_rel <= REL_NONE;
    end
  end

  // four-phase req/ack around the online window
  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      next_cpu_ack <= 1'b0;
      ring.online <= 1'b0;
    end else if (next_cpu_ack) begin
      // ring let go of the request, token passes on
      if (!next_cpu_req) begin
        next_cpu_ack <= 1'b0;
        ring.online <= 1'b0;
      end
    end else if (ring.online) begin
      if (ring.done) begin
        next_cpu_ack <= 1'b1;
      end
    end else if (match) begin
      ring.online <= 1'b1;
    end
  end

  a_ack_needs_req: assert property (
    @(posedge clk) disable iff (ext_rst_b) $rose(next_cpu_ack) |-> $past(next_cpu_req)
  );

endmodule

//--- verilog/thread_messenger.sv
`timescale 1ns/1ps

`include "bridge_settings.svh"

module thread_messenger (
  input  logic                      clk,
  input  logic                      ext_rst_b,
  input  bridge_pkg::core_state_e   core_state,
  input  logic [`BRIDGE_DATA_W-1:0] addr_in,
  input  logic [`BRIDGE_DATA_W-1:0] data_in,
  input  logic                      read_q,
  input  logic                      write_q,
  input  logic                      read_dn,
  input  logic                      write_dn,
  input  logic                      rw_halt,
  input  logic                      chan_op,
  input  logic                      idle_exit,
  input  bridge_pkg::cpu_msg_e      ext_cpu_msg_in,
  input  bridge_pkg::cpu_msg_e      int_cpu_msg_in,
  input  bridge_pkg::cpu_msg_e      reset_msg,
  ring_if.msg                       ring,
  output logic [`BRIDGE_DATA_W-1:0] base_addr,
  output logic [`BRIDGE_DATA_W-1:0] base_addr_data,
  output bridge_pkg::cpu_msg_e      ext_cpu_msg,
  output bridge_pkg::cpu_msg_e      int_cpu_msg_out,
  output logic                      next_state,
  output logic                      ext_read_q,
  output logic                      ext_write_q,
  output logic                      dispatch_req
);
  import bridge_pkg::*;

  localparam logic [`BRIDGE_DATA_W-1:0] HDR = `BRIDGE_HEADER_SPACE;

  cpu_msg_e held_msg;
  logic     online_d;
  logic     first_online;
  logic     ns_pulse;
  logic     in_read;
  logic     in_write;
  logic     inbound_done;
  logic     inbound_chan;
  logic     serve_done;

  assign in_read = core_state inside {READ_COND, READ_SRC1, READ_SRC0, READ_DST,
                                      START_READ_CMD, READ_MEM_SIZE};
  assign in_write = core_state inside {WRITE_REG_IP, WRITE_DST, WRITE_SRC1,
                                       WRITE_SRC0, WRITE_COND};
  // completion codes from other cores
  assign inbound_chan = ext_cpu_msg_in inside {CHAN_NO_RESULTS, CHAN_RES_RD, CHAN_RES_WR};
  assign inbound_done = inbound_chan || (ext_cpu_msg_in inside {FORK_DONE, STOP_DONE});
  assign first_online = ring.online && !online_d;

  // when the current state lets the token go
  always_comb begin
    if (in_read || in_write) begin
      serve_done = rw_halt || read_dn || write_dn || chan_op;
    end else if (core_state == ALU_BEGIN) begin
      serve_done = inbound_done;
    end else begin
      // start, finish and the rest complete right away
      serve_done = 1'b1;
    end
  end

  assign ring.done = ring.online && serve_done;

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      online_d <= 1'b0;
      held_msg <= NONE;
      ns_pulse <= 1'b0;
      dispatch_req <= 1'b0;
    end else begin
      online_d <= ring.online;
      ns_pulse <= 1'b0;
      // request stands until the bridge restarts
      if (!ring.running) begin
        dispatch_req <= 1'b0;
      end
      if (first_online) begin
        case (core_state)
          WAIT_FOR_START: begin
            held_msg <= START;
            ns_pulse <= 1'b1;
          end
          FINISH_BEGIN: begin
            held_msg <= END;
            ns_pulse <= 1'b1;
            dispatch_req <= 1'b1;
          end
          default: held_msg <= NONE;
        endcase
      end else if (!ring.online && online_d) begin
        // token gone, message delivered
        held_msg <= NONE;
      end
      if (ring.online && core_state == ALU_BEGIN && inbound_chan) begin
        dispatch_req <= 1'b1;
      end
    end
  end

  // thread base addresses, past the header
  always_ff @(posedge clk) begin
    if (first_online && core_state == WAIT_FOR_START) begin
      base_addr <= addr_in + HDR;
      // no data segment, data shares the code base
      base_addr_data <= (data_in == '0) ? addr_in + HDR : data_in + HDR;
    end
  end

  always_comb begin
    if (int_cpu_msg_in != NONE) begin
      ext_cpu_msg = int_cpu_msg_in;
    end else if (reset_msg != NONE) begin
      ext_cpu_msg = reset_msg;
    end else begin
      ext_cpu_msg = held_msg;
    end
  end

  assign int_cpu_msg_out = inbound_done ? ext_cpu_msg_in : NONE;

  // bus requests only pass with the token held
  assign ext_read_q = in_read && ring.online && read_q;
  assign ext_write_q = in_write && ring.online && write_q;

  assign next_state = ns_pulse || (in_read && idle_exit);

  // no bus read while the reset sequence is still in progress
  a_read_while_running: assert property (
    @(posedge clk) disable iff (ext_rst_b) ext_read_q |-> ring.running
  );

endmodule

//--- verilog/idle_watchdog.sv
`timescale 1ns/1ps

`include "bridge_settings.svh"

module idle_watchdog (
  input  logic clk,
  input  logic ext_rst_b,
  input  logic no_data_new,
  input  logic no_data_tick,
  output logic idle_exit
);

  localparam int CNT_W = $clog2(`BRIDGE_IDLE_MAX + 1);
  localparam logic [CNT_W-1:0] CNT_MAX = `BRIDGE_IDLE_MAX;

  logic [CNT_W-1:0] idle_cnt;

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      idle_cnt <= '0;
      idle_exit <= 1'b0;
    end else if (no_data_new) begin
      // fresh data, start over
      idle_cnt <= '0;
      idle_exit <= 1'b0;
    end else if (no_data_tick) begin
      if (idle_cnt == CNT_MAX) begin
        idle_exit <= 1'b1;
      end else begin
        idle_cnt <= idle_cnt + 1'b1;
      end
    end
  end

endmodule

//--- verilog/bridge_top.sv
`timescale 1ns/1ps

`include "bridge_settings.svh"

module bridge_top (
  input  logic                      clk,
  input  logic                      ext_rst_b,
  input  bridge_pkg::core_state_e   core_state,
  input  logic [`BRIDGE_DATA_W-1:0] cpu_index,
  input  logic                      next_cpu_req,
  input  logic [`BRIDGE_DATA_W-1:0] addr_in,
  input  logic [`BRIDGE_DATA_W-1:0] data_in,
  input  logic                      read_q,
  input  logic                      write_q,
  input  logic                      read_dn,
  input  logic                      write_dn,
  input  logic                      rw_halt,
  input  logic                      chan_op,
  input  logic                      no_data_new,
  input  logic                      no_data_tick,
  input  bridge_pkg::cpu_msg_e      ext_cpu_msg_in,
  input  bridge_pkg::cpu_msg_e      int_cpu_msg_in,
  output logic                      next_cpu_ack,
  output bridge_pkg::cpu_rel_e      cpu_ind_rel,
  output logic                      core_rst,
  output logic                      ext_rst_e,
  output logic                      dispatcher_q,
  output logic                      bus_busy,
  output logic [`BRIDGE_DATA_W-1:0] base_addr,
  output logic [`BRIDGE_DATA_W-1:0] base_addr_data,
  output bridge_pkg::cpu_msg_e      ext_cpu_msg,
  output bridge_pkg::cpu_msg_e      int_cpu_msg_out,
  output logic                      next_state,
  output logic                      ext_read_q,
  output logic                      ext_write_q,
  output logic                      idle_exit
);
  import bridge_pkg::*;

  cpu_msg_e reset_msg;
  logic     seq_dispatch;
  logic     msg_dispatch;

  ring_if ring ();

  reset_sequencer u_seq (
    .clk          (clk),
    .ext_rst_b    (ext_rst_b),
    .core_state   (core_state),
    .cpu_index    (cpu_index),
    .ring         (ring.seq),
    .core_rst     (core_rst),
    .ext_rst_e    (ext_rst_e),
    .dispatcher_q (seq_dispatch),
    .bus_busy     (bus_busy),
    .reset_msg    (reset_msg)
  );

  token_handshake u_hs (
    .clk          (clk),
    .ext_rst_b    (ext_rst_b),
    .next_cpu_req (next_cpu_req),
    .cpu_index    (cpu_index),
    .ring         (ring.hs),
    .next_cpu_ack (next_cpu_ack),
    .cpu_ind_rel  (cpu_ind_rel)
  );

  thread_messenger u_msg (
    .clk             (clk),
    .ext_rst_b       (ext_rst_b),
    .core_state      (core_state),
    .addr_in         (addr_in),
    .data_in         (data_in),
    .read_q          (read_q),
    .write_q         (write_q),
    .read_dn         (read_dn),
    .write_dn        (write_dn),
    .rw_halt         (rw_halt),
    .chan_op         (chan_op),
    .idle_exit       (idle_exit),
    .ext_cpu_msg_in  (ext_cpu_msg_in),
    .int_cpu_msg_in  (int_cpu_msg_in),
    .reset_msg       (reset_msg),
    .ring            (ring.msg),
    .base_addr       (base_addr),
    .base_addr_data  (base_addr_data),
    .ext_cpu_msg     (ext_cpu_msg),
    .int_cpu_msg_out (int_cpu_msg_out),
    .next_state      (next_state),
    .ext_read_q      (ext_read_q),
    .ext_write_q     (ext_write_q),
    .dispatch_req    (msg_dispatch)
  );

  idle_watchdog u_idle (
    .clk          (clk),
    .ext_rst_b    (ext_rst_b),
    .no_data_new  (no_data_new),
    .no_data_tick (no_data_tick),
    .idle_exit    (idle_exit)
  );

  // dispatcher asked for by the sequencer or by a served thread
  assign dispatcher_q = seq_dispatch || msg_dispatch;

endmodule

//--- verif/tb_clock.sv
`timescale 1ns/1ps

// free-running testbench clock, 40 ns period
module tb_clock (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  // half period
  always #20 clk = ~clk;

endmodule

//--- verif/bridge_tb.sv
`timescale 1ns/1ps

`include "bridge_settings.svh"

module bridge_tb;
  import bridge_pkg::*;

  localparam int MAX_CASES = 32;

  logic clk, ext_rst_b, next_cpu_req, read_q, write_q, read_dn, write_dn;
  logic rw_halt, chan_op, no_data_new, no_data_tick;
  core_state_e core_state;
  logic [`BRIDGE_DATA_W-1:0] cpu_index, addr_in, data_in, base_addr, base_addr_data;
  cpu_msg_e ext_cpu_msg_in, int_cpu_msg_in, ext_cpu_msg, int_cpu_msg_out;
  logic next_cpu_ack, core_rst, ext_rst_e, dispatcher_q, bus_busy;
  logic next_state, ext_read_q, ext_write_q, idle_exit;
  cpu_rel_e cpu_ind_rel;

  // case table, one entry per line of the case file
  int c_kind[MAX_CASES];
  int c_state[MAX_CASES];
  int c_msg[MAX_CASES];
  int c_emsg[MAX_CASES];
  logic [31:0] c_idx[MAX_CASES];
  logic [31:0] c_addr[MAX_CASES];
  logic [31:0] c_data[MAX_CASES];
  logic [31:0] c_ea[MAX_CASES];
  logic [31:0] c_eb[MAX_CASES];

  int n_cases = 0;
  int test_errs = 0;
  int cycles = 0;
  int limit = 0;
  logic [31:0] lfsr = 32'hc8df_ed43;
  logic [31:0] my_idx = '0;

  tb_clock u_clk (.clk(clk));

  bridge_top dut (.*);

  // run limit, scaled by the number of cases
  always @(posedge clk) begin
    cycles++;
    if (limit > 0 && cycles > limit) begin
      $display("timeout: run went past %0d cycles", limit);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one lfsr step per bit
  task automatic random_word(output logic [31:0] w);
    for (int b = 0; b < 32; b++) begin
      w[b] = lfsr[0];
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // ordering on the bits below the active bit
  function automatic cpu_rel_e rel_of(input logic [31:0] ring, input logic [31:0] own);
    if (ring[30:0] < own[30:0]) return REL_LOWER;
    if (ring[30:0] > own[30:0]) return REL_HIGHER;
    return REL_SAME;
  endfunction

  task automatic check_msg(input string name, input cpu_msg_e got, input cpu_msg_e exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
      test_errs++;
    end
  endtask

  task automatic check_rel(input string name, input cpu_rel_e got, input cpu_rel_e exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
      test_errs++;
    end
  endtask

  task automatic check_word(input string name, input logic [`BRIDGE_DATA_W-1:0] got,
                            input logic [`BRIDGE_DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      test_errs++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      test_errs++;
    end
  endtask

  task automatic report_fail(input string what);
    $display("error at %0t: %s", $time, what);
    test_errs++;
  endtask

  // inputs change shortly after the rising edge
  task automatic next_drive();
    @(posedge clk);
    #2;
  endtask

  task automatic wait_ack(input logic val, input int max, output bit seen);
    seen = 0;
    for (int k = 0; k < max && !seen; k++) begin
      @(negedge clk);
      if (next_cpu_ack === val) seen = 1;
    end
  endtask

  // ring drops the request, done inputs go quiet
  task automatic release_token();
    bit seen;
    next_drive();
    next_cpu_req = 1'b0;
    read_dn = 1'b0;
    write_dn = 1'b0;
    chan_op = 1'b0;
    ext_cpu_msg_in = NONE;
    wait_ack(1'b0, 8, seen);
    if (!seen) report_fail("ack stayed high after the request was dropped");
  endtask

  task automatic request_own();
    next_drive();
    cpu_index = my_idx;
    next_cpu_req = 1'b1;
  endtask

  task automatic run_reset(input int i);
    int rst_cnt, ext_cnt, msg_cnt, busy_cnt;
    rst_cnt = 0;
    ext_cnt = 0;
    msg_cnt = 0;
    busy_cnt = 0;
    ext_rst_b = 1'b1;
    core_state = WAIT_FOR_START;
    cpu_index = c_idx[i];
    repeat (3) next_drive();
    @(negedge clk);
    check_bit("core_rst", core_rst, 1'b0);
    check_bit("bus_busy", bus_busy, 1'b0);
    check_bit("dispatcher_q", dispatcher_q, 1'b0);
    check_rel("cpu_ind_rel", cpu_ind_rel, REL_NONE);
    next_drive();
    ext_rst_b = 1'b0;
    repeat (8) begin
      @(negedge clk);
      rst_cnt += int'(core_rst);
      ext_cnt += int'(ext_rst_e);
      busy_cnt += int'(bus_busy);
      if (ext_cpu_msg == RESET) msg_cnt++;
      check_bit("next_cpu_ack", next_cpu_ack, 1'b0);
    end
    check_word("core_rst pulses", rst_cnt, c_ea[i]);
    check_word("bus_busy pulses", busy_cnt, c_ea[i]);
    check_word("ext_rst_e pulses", ext_cnt, c_eb[i]);
    check_word("reset message cycles", msg_cnt, c_emsg[i]);
    check_bit("dispatcher_q", dispatcher_q, 1'b1);
    my_idx = c_idx[i];
  endtask

  task automatic run_foreign(input int i);
    logic [31:0] idx;
    cpu_rel_e exp;
    bit seen;
    idx = c_idx[i];
    exp = cpu_rel_e'(c_ea[i][1:0]);
    // zero index in the file means a random filler index
    if (idx == '0) begin
      random_word(idx);
      exp = rel_of(idx, my_idx);
    end
    next_drive();
    cpu_index = idx;
    next_cpu_req = 1'b1;
    wait_ack(1'b1, 10, seen);
    if (seen) report_fail("request with a foreign index was acknowledged");
    check_rel("cpu_ind_rel", cpu_ind_rel, exp);
    next_drive();
    next_cpu_req = 1'b0;
  endtask

  task automatic run_start(input int i);
    bit seen;
    next_drive();
    core_state = WAIT_FOR_START;
    addr_in = c_addr[i];
    data_in = c_data[i];
    request_own();
    wait_ack(1'b1, 10, seen);
    if (!seen) begin
      report_fail("no ack for a matching request at thread start");
    end else begin
      check_msg("ext_cpu_msg", ext_cpu_msg, cpu_msg_e'(c_emsg[i][3:0]));
      check_word("base_addr", base_addr, c_ea[i]);
      check_word("base_addr_data", base_addr_data, c_eb[i]);
      check_rel("cpu_ind_rel", cpu_ind_rel, REL_SAME);
    end
    release_token();
    // held message goes on the edge after the token is gone
    @(negedge clk);
    check_msg("ext_cpu_msg", ext_cpu_msg, NONE);
  endtask

  task automatic run_bus(input int i);
    bit seen;
    logic is_read;
    next_drive();
    core_state = core_state_e'(c_state[i][4:0]);
    is_read = (c_state[i] >= 1 && c_state[i] <= 6);
    read_q = is_read;
    write_q = !is_read;
    @(negedge clk);
    check_bit("ext_read_q", ext_read_q, 1'b0);
    check_bit("ext_write_q", ext_write_q, 1'b0);
    request_own();
    repeat (2) @(negedge clk);
    check_bit("ext_read_q", ext_read_q, is_read);
    check_bit("ext_write_q", ext_write_q, !is_read);
    check_bit("next_cpu_ack", next_cpu_ack, 1'b0);
    next_drive();
    read_dn = is_read;
    chan_op = !is_read;
    wait_ack(1'b1, 8, seen);
    if (!seen) report_fail("bus completion gave no ack");
    release_token();
    @(negedge clk);
    check_bit("ext_read_q", ext_read_q, 1'b0);
    check_bit("ext_write_q", ext_write_q, 1'b0);
    next_drive();
    read_q = 1'b0;
    write_q = 1'b0;
  endtask

  task automatic run_alu(input int i);
    bit seen;
    next_drive();
    core_state = ALU_BEGIN;
    ext_cpu_msg_in = cpu_msg_e'(c_msg[i][3:0]);
    cpu_index = my_idx;
    next_cpu_req = 1'b1;
    @(negedge clk);
    check_msg("int_cpu_msg_out", int_cpu_msg_out, cpu_msg_e'(c_emsg[i][3:0]));
    wait_ack(1'b1, 8, seen);
    check_bit("next_cpu_ack", seen, c_ea[i][0]);
    if (!seen) begin
      // a completion is still needed to hand the token on
      next_drive();
      ext_cpu_msg_in = FORK_DONE;
      wait_ack(1'b1, 8, seen);
      if (!seen) report_fail("completion message gave no ack");
    end
    check_bit("dispatcher_q", dispatcher_q, c_eb[i][0]);
    release_token();
  endtask

  task automatic run_idle(input int i);
    bit seen;
    next_drive();
    no_data_tick = 1'b1;
    repeat (c_addr[i]) @(posedge clk);
    #2;
    no_data_tick = 1'b0;
    @(negedge clk);
    check_bit("idle_exit", idle_exit, c_ea[i][0]);
    next_drive();
    core_state = READ_COND;
    request_own();
    repeat (2) @(negedge clk);
    check_bit("next_state", next_state, 1'b1);
    next_drive();
    read_dn = 1'b1;
    wait_ack(1'b1, 8, seen);
    if (!seen) report_fail("read_dn gave no ack");
    release_token();
    next_drive();
    no_data_new = 1'b1;
    next_drive();
    no_data_new = 1'b0;
    @(negedge clk);
    check_bit("idle_exit", idle_exit, 1'b0);
  endtask

  initial begin
    int fd, cnt, passed, failed, errors;
    string line;
    ext_rst_b = 1'b1;
    core_state = OTHER;
    cpu_index = '0;
    next_cpu_req = 1'b0;
    addr_in = '0;
    data_in = '0;
    read_q = 1'b0;
    write_q = 1'b0;
    read_dn = 1'b0;
    write_dn = 1'b0;
    rw_halt = 1'b0;
    chan_op = 1'b0;
    no_data_new = 1'b0;
    no_data_tick = 1'b0;
    ext_cpu_msg_in = NONE;
    int_cpu_msg_in = NONE;
    passed = 0;
    failed = 0;
    errors = 0;
    fd = $fopen("verif/bridge_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open the case file");
      $display("RESULT: FAIL");
      $finish;
    end else begin
      while (!$feof(fd) && n_cases < MAX_CASES) begin
        cnt = $fgets(line, fd);
        if (line.len() < 2 || line[0] == 8'h23) continue;
        cnt = $sscanf(line, "%d %d %h %h %h %d %d %h %h", c_kind[n_cases],
                      c_state[n_cases], c_idx[n_cases], c_addr[n_cases], c_data[n_cases],
                      c_msg[n_cases], c_emsg[n_cases], c_ea[n_cases], c_eb[n_cases]);
        if (cnt == 9) n_cases++;
      end
      $fclose(fd);
      limit = 40 * n_cases + 20;
      for (int i = 0; i < n_cases; i++) begin
        test_errs = 0;
        case (c_kind[i])
          0: run_reset(i);
          1: run_foreign(i);
          2: run_start(i);
          3: run_bus(i);
          4: run_alu(i);
          5: run_idle(i);
          default: report_fail("unknown test kind in the case file");
        endcase
        next_drive();
        core_state = OTHER;
        $display("test %0d kind %0d: %s", i, c_kind[i], (test_errs == 0) ? "ok" : "failed");
        errors += test_errs;
        if (test_errs == 0) passed++;
        else failed++;
      end
      $display("tests %0d passed %0d failed %0d errors %0d", n_cases, passed, failed, errors);
      if (errors == 0 && n_cases > 0) begin
        $display("RESULT: PASS");
      end else begin
        $display("RESULT: FAIL");
      end
      $finish;
    end
  end

endmodule

//--- verif/bridge_cases.txt
# kind state index addr data msg exp_msg exp_a exp_b (index..data, exp_a, exp_b in hex)
# kinds 0 reset 1 foreign 2 start 3 bus 4 alu 5 idle, states and messages as enum codes
0 0 00000010 00000000 00000000 0 1 00000001 00000001
1 0 00000004 00000000 00000000 0 0 00000001 00000000
1 0 00000020 00000000 00000000 0 0 00000002 00000000
1 0 80000004 00000000 00000000 0 0 00000001 00000000
1 0 00000000 00000000 00000000 0 0 00000000 00000000
2 0 00000010 00001000 00002000 0 2 00001008 00002008
2 0 00000010 00003000 00000000 0 2 00003008 00003008
3 1 00000010 00000000 00000000 0 0 00000000 00000000
3 8 00000010 00000000 00000000 0 0 00000000 00000000
4 12 00000010 00000000 00000000 4 4 00000001 00000001
4 12 00000010 00000000 00000000 5 5 00000001 00000001
4 12 00000010 00000000 00000000 6 6 00000001 00000001
4 12 00000010 00000000 00000000 8 8 00000001 00000001
4 12 00000010 00000000 00000000 2 0 00000000 00000001
4 12 00000010 00000000 00000000 1 0 00000000 00000001
5 1 00000010 00000010 00000000 0 0 00000001 00000000

//--- project.f
+incdir+include
verilog/bridge_pkg.sv
verilog/ring_if.sv
verilog/reset_sequencer.sv
verilog/token_handshake.sv
verilog/thread_messenger.sv
verilog/idle_watchdog.sv
verilog/bridge_top.sv
verif/tb_clock.sv
verif/bridge_tb.sv

//--- run.sh
#!/bin/sh
# build and run the bridge testbench, fail status on any reported failure
verilator --binary --timing --assert -f project.f --top-module bridge_tb -o bridge_sim \
  > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/bridge_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1 || exit 0
